//--- src/dotp_consts.svh
// ------------------------------------------------
// Dot-product engine constants
// Memory map, lane count, data widths and the
// depth of the column FIFO
// ------------------------------------------------
`ifndef DOTP_CONSTS_SVH
`define DOTP_CONSTS_SVH

// Memory map
`define DOTP_ROW_BASE    64'h0000_0004_0000_0000 // One 512-bit row beat
`define DOTP_COL_BASE    64'h0000_0004_0001_0000 // Column element 0
`define DOTP_COL_STRIDE  64'd64                  // One beat per column element
`define DOTP_RES_BASE    64'h0000_0004_0002_0000 // First result word
`define DOTP_RES_STRIDE  64'd8                   // One 64-bit result per run

// Vector shape
`define DOTP_LANES       16
`define DOTP_BEAT_W      512

// Data widths
`define DOTP_ELEM_W      32
`define DOTP_ACC_W       64
`define DOTP_ADDR_W      64
`define DOTP_IDX_W       5  // Must reach DOTP_LANES itself

// Column buffering
`define DOTP_FIFO_DEPTH  4

`endif

//--- src/dotp_pkg.sv
// ------------------------------------------------
// Dot-product engine types
// Element, accumulator, index and address words,
// plus the two views of a returned read beat
// ------------------------------------------------
`default_nettype none

`include "dotp_consts.svh"

package dotp_pkg;

  typedef logic signed [`DOTP_ELEM_W-1:0] elem_t;
  typedef logic signed [`DOTP_ACC_W-1:0]  acc_t;
  typedef logic [`DOTP_IDX_W-1:0]         idx_t;
  typedef logic [`DOTP_ADDR_W-1:0]        addr_t;

  // Row beat carries all lanes, lane 0 lowest
  // Column beat only uses its low element
  typedef union packed {
    elem_t [`DOTP_LANES-1:0] row;
    struct packed {
      logic [`DOTP_BEAT_W-`DOTP_ELEM_W-1:0] pad;
      elem_t                                val;
    } col;
  } rbeat_u;

endpackage

`default_nettype wire

//--- src/dotp_ctrl.sv
// ------------------------------------------------
// Dot-product control FSM
// Sequences the row read, the sixteen column reads,
// the MAC drain and the single result write
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dotp_consts.svh"

module dotp_ctrl (
  input  logic            clk,
  input  logic            sync_rst_n,
  input  logic            start,
  input  logic            ar_ready,
  input  logic            r_valid,
  output logic            r_ready,
  output logic            ar_valid,
  output dotp_pkg::addr_t ar_addr,
  output logic            wr_valid,
  input  logic            wr_ready,
  output dotp_pkg::addr_t wr_addr,
  output logic            busy,
  output logic            done,
  input  logic            fifo_full,
  input  logic            req_done,
  input  logic            mac_done,
  input  dotp_pkg::idx_t  req_idx,
  output logic            row_cap,
  output logic            col_push,
  output logic            req_inc,
  output logic            clr
);

  typedef enum logic [2:0] {
    IDLE,
    ROW_REQ,
    ROW_WAIT,
    COL_REQ,
    DRAIN,
    WRITE
  } state_t;

  state_t          state;
  state_t          state_nxt;
  logic            col_phase;
  dotp_pkg::addr_t col_addr;

  // Column beats may arrive while requests are still going out
  assign col_phase = (state == COL_REQ) || (state == DRAIN);
  assign col_addr  = `DOTP_COL_BASE + (dotp_pkg::addr_t'(req_idx) * `DOTP_COL_STRIDE);

  // ------------------------------------------------
  // Read request and response handshakes
  // ------------------------------------------------
  assign ar_valid = (state == ROW_REQ) || ((state == COL_REQ) && !req_done);
  assign ar_addr  = (state == ROW_REQ) ? `DOTP_ROW_BASE : col_addr;
  assign req_inc  = (state == COL_REQ) && ar_valid && ar_ready;

  assign r_ready  = (state == ROW_WAIT) || (col_phase && !fifo_full);
  assign row_cap  = (state == ROW_WAIT) && r_valid;
  assign col_push = col_phase && r_valid && r_ready;

  assign clr      = (state == IDLE) && start; // Start ignored once running
  assign wr_valid = (state == WRITE);
  assign busy     = (state != IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:     if (start) state_nxt = ROW_REQ;
      ROW_REQ:  if (ar_ready) state_nxt = ROW_WAIT;
      ROW_WAIT: if (r_valid) state_nxt = COL_REQ;
      COL_REQ:  if (req_done) state_nxt = DRAIN;
      DRAIN:    if (mac_done) state_nxt = WRITE; // Accumulator final here
      WRITE:    if (wr_ready) state_nxt = IDLE;
      default:  state_nxt = IDLE;
    endcase
  end

  // ------------------------------------------------
  // State, result address and done pulse
  // ------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      state   <= IDLE;
      wr_addr <= `DOTP_RES_BASE;
      done    <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= wr_valid && wr_ready;
      if (wr_valid && wr_ready) begin
        wr_addr <= wr_addr + `DOTP_RES_STRIDE; // Next run lands one word up
      end
    end
  end

  // A stalled read request must not change under the memory
  ar_hold_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

endmodule

`default_nettype wire

//--- src/dotp_counter.sv
// ------------------------------------------------
// Element counters
// Tracks column requests issued and products
// accumulated, each saturating at the lane count
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dotp_consts.svh"

module dotp_counter (
  input  logic           clk,
  input  logic           sync_rst_n,
  input  logic           clr,
  input  logic           req_inc,
  input  logic           pop,
  output dotp_pkg::idx_t req_idx,
  output dotp_pkg::idx_t mac_idx,
  output logic           req_done,
  output logic           mac_done
);

  localparam dotp_pkg::idx_t LANES = `DOTP_LANES;

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      req_idx <= '0;
      mac_idx <= '0;
    end else if (clr) begin
      req_idx <= '0;
      mac_idx <= '0;
    end else begin
      if (req_inc) req_idx <= req_idx + 1'b1;
      if (pop)     mac_idx <= mac_idx + 1'b1; // One product per popped column
    end
  end

  assign req_done = (req_idx == LANES);
  assign mac_done = (mac_idx == LANES);

  // Ctrl and FIFO must never drive a seventeenth element
  req_cap_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
    req_inc |-> req_idx < LANES);
  mac_cap_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
    pop |-> mac_idx < LANES);

endmodule

`default_nettype wire

//--- src/row_buffer.sv
// ------------------------------------------------
// Row buffer
// Holds the sixteen row elements and hands the
// MAC the lane picked by the product index
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dotp_consts.svh"

module row_buffer (
  input  logic            clk,
  input  logic            sync_rst_n,
  input  logic            row_cap,
  input  dotp_pkg::rbeat_u r_data,
  input  dotp_pkg::idx_t  mac_idx,
  output dotp_pkg::elem_t row_elem
);

  localparam int SEL_W = $clog2(`DOTP_LANES);

  dotp_pkg::elem_t [`DOTP_LANES-1:0] row_q;

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      row_q <= '0;
    end else if (row_cap) begin
      row_q <= r_data.row; // Whole beat in one cycle
    end
  end

  // Index of LANES means all products done, present zero
  always_comb begin
    if (mac_idx < `DOTP_LANES) begin
      row_elem = row_q[mac_idx[SEL_W-1:0]];
    end else begin
      row_elem = '0;
    end
  end

endmodule

`default_nettype wire

//--- src/col_fifo.sv
// ------------------------------------------------
// Column element FIFO
// Small first-word-fall-through buffer between the
// read data port and the MAC
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dotp_consts.svh"

module col_fifo (
  input  logic            clk,
  input  logic            sync_rst_n,
  input  logic            push,
  input  dotp_pkg::elem_t din,
  input  logic            pop,
  output dotp_pkg::elem_t dout,
  output logic            full,
  output logic            empty
);

  localparam int DEPTH = `DOTP_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  dotp_pkg::elem_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // Storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  assign dout  = mem[rd_ptr]; // Head is visible without a read cycle
  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);

  no_overflow_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
    push |-> !full);
  no_underflow_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
    pop |-> !empty);

endmodule

`default_nettype wire

//--- src/mac_unit.sv
// ------------------------------------------------
// Multiply-accumulate unit
// Signed 32x32 product added into a 64-bit sum,
// one term per popped column element
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
  input  logic            clk,
  input  logic            sync_rst_n,
  input  logic            clr,
  input  logic            pop,
  input  dotp_pkg::elem_t row_elem,
  input  dotp_pkg::elem_t col_elem,
  output dotp_pkg::acc_t  acc
);

  dotp_pkg::acc_t row_ext;
  dotp_pkg::acc_t col_ext;
  dotp_pkg::acc_t prod;

  // Both operands signed, so the casts sign-extend
  assign row_ext = dotp_pkg::acc_t'(row_elem);
  assign col_ext = dotp_pkg::acc_t'(col_elem);
  assign prod    = row_ext * col_ext; // Full product fits in 64 bits

  // ------------------------------------------------
  // Accumulator
  // ------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      acc <= '0;
    end else if (clr) begin
      acc <= '0;
    end else if (pop) begin
      acc <= acc + prod;
    end
  end

endmodule

`default_nettype wire

//--- src/dotp_top.sv
// ------------------------------------------------
// Dot-product engine top
// Reads one row beat and sixteen column beats,
// then writes the signed 64-bit dot product
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dotp_top (
  input  logic             clk,
  input  logic             sync_rst_n,
  input  logic             start,
  output logic             ar_valid,
  output dotp_pkg::addr_t  ar_addr,
  input  logic             ar_ready,
  input  logic             r_valid,
  input  dotp_pkg::rbeat_u r_data,
  output logic             r_ready,
  output logic             wr_valid,
  output dotp_pkg::addr_t  wr_addr,
  output dotp_pkg::acc_t   wr_data,
  input  logic             wr_ready,
  output logic             busy,
  output logic             done
);

  logic            row_cap;
  logic            col_push;
  logic            req_inc;
  logic            clr;
  logic            fifo_full;
  logic            fifo_empty;
  logic            fifo_pop;
  logic            req_done;
  logic            mac_done;
  dotp_pkg::idx_t  req_idx;
  dotp_pkg::idx_t  mac_idx;
  dotp_pkg::elem_t row_elem;
  dotp_pkg::elem_t col_elem;

  assign fifo_pop = !fifo_empty; // MAC takes a term whenever one is waiting

  dotp_ctrl dotp_ctrl_inst (
    .clk       (clk),
    .sync_rst_n(sync_rst_n),
    .start     (start),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .ar_valid  (ar_valid),
    .ar_addr   (ar_addr),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_addr   (wr_addr),
    .busy      (busy),
    .done      (done),
    .fifo_full (fifo_full),
    .req_done  (req_done),
    .mac_done  (mac_done),
    .req_idx   (req_idx),
    .row_cap   (row_cap),
    .col_push  (col_push),
    .req_inc   (req_inc),
    .clr       (clr)
  );

  dotp_counter dotp_counter_inst (
    .clk(clk), .sync_rst_n(sync_rst_n), .clr(clr), .req_inc(req_inc), .pop(fifo_pop),
    .req_idx(req_idx), .mac_idx(mac_idx), .req_done(req_done), .mac_done(mac_done)
  );

  row_buffer row_buffer_inst (
    .clk(clk), .sync_rst_n(sync_rst_n), .row_cap(row_cap), .r_data(r_data),
    .mac_idx(mac_idx), .row_elem(row_elem)
  );

  // Column view: element sits in the low 32 bits of the beat
  col_fifo col_fifo_inst (
    .clk(clk), .sync_rst_n(sync_rst_n), .push(col_push), .din(r_data.col.val),
    .pop(fifo_pop), .dout(col_elem), .full(fifo_full), .empty(fifo_empty)
  );

  mac_unit mac_unit_inst (
    .clk(clk), .sync_rst_n(sync_rst_n), .clr(clr), .pop(fifo_pop),
    .row_elem(row_elem), .col_elem(col_elem), .acc(wr_data)
  );

endmodule

`default_nettype wire

//--- test/tb_dotp.sv
// ------------------------------------------------
// Dot-product engine testbench
// Memory model with random stalls, reference dot
// product and handshake-time checks over 8 runs
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dotp_consts.svh"

module tb_dotp;

  localparam int RUNS       = 8;
  localparam int MAX_CYCLES = RUNS * 400; // Generous bound for 17 reads plus stalls

  logic             clk;
  logic             sync_rst_n;
  logic             start;
  logic             ar_valid;
  dotp_pkg::addr_t  ar_addr;
  logic             ar_ready;
  logic             r_valid;
  dotp_pkg::rbeat_u r_data;
  logic             r_ready;
  logic             wr_valid;
  dotp_pkg::addr_t  wr_addr;
  dotp_pkg::acc_t   wr_data;
  logic             wr_ready;
  logic             busy;
  logic             done;

  integer           seed;
  int               err_count;
  int               cycles;
  logic             heavy;      // Long stalls on every port
  logic             burst_on;
  int               burst_len;

  dotp_pkg::elem_t  row_mem [`DOTP_LANES];
  dotp_pkg::elem_t  col_mem [`DOTP_LANES];
  dotp_pkg::addr_t  rd_q [$];   // Accepted reads awaiting data
  dotp_pkg::acc_t   exp_acc;
  dotp_pkg::addr_t  exp_wr_addr;
  logic             exp_busy;
  logic             exp_done;
  int               rd_count;
  int               wr_count;

  dotp_top dotp_top_inst (
    .clk(clk), .sync_rst_n(sync_rst_n), .start(start),
    .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
    .r_valid(r_valid), .r_data(r_data), .r_ready(r_ready),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .wr_ready(wr_ready),
    .busy(busy), .done(done)
  );

  always #2 clk = ~clk;

  // ------------------------------------------------
  // Reference model and compare tasks
  // ------------------------------------------------
  function automatic dotp_pkg::acc_t dot_ref(input dotp_pkg::elem_t a [`DOTP_LANES],
                                             input dotp_pkg::elem_t b [`DOTP_LANES]);
    longint sum;
    sum = 0;
    for (int i = 0; i < `DOTP_LANES; i++) begin
      sum += longint'(a[i]) * longint'(b[i]); // Signed, wraps like a 64-bit register
    end
    return dotp_pkg::acc_t'(sum);
  endfunction

  task automatic abort_with(input string why);
    err_count++;
    $display("%s at %0t", why, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_acc(input string name, input dotp_pkg::acc_t got,
                           input dotp_pkg::acc_t exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s expected=%h got=%h", $time, name, exp, got);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_addr(input string name, input dotp_pkg::addr_t got,
                            input dotp_pkg::addr_t exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s expected=%h got=%h", $time, name, exp, got);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR t=%0t %s expected=%b got=%b", $time, name, exp, got);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ------------------------------------------------
  // Memory model
  // ------------------------------------------------
  function automatic dotp_pkg::rbeat_u make_beat(input dotp_pkg::addr_t a);
    dotp_pkg::rbeat_u beat;
    int               k;
    if (a == `DOTP_ROW_BASE) begin
      for (int i = 0; i < `DOTP_LANES; i++) beat.row[i] = row_mem[i];
    end else begin
      k = int'((a - `DOTP_COL_BASE) / `DOTP_COL_STRIDE);
      for (int j = 0; j < 15; j++) beat.col.pad[j*32 +: 32] = $random(seed); // Junk above
      beat.col.val = col_mem[k];
    end
    return beat;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      abort_with("Timeout: the engine did not finish all runs in time");
    end else begin
      ar_ready <= heavy ? (($random(seed) & 3) == 0) : (($random(seed) & 3) != 0);
      wr_ready <= heavy ? (($random(seed) & 3) == 0) : (($random(seed) & 1) != 0);
      if (burst_len == 0) begin
        burst_on  = !burst_on;
        burst_len = burst_on ? ($random(seed) & 15) + 1 : (heavy ? ($random(seed) & 7) + 1 : 1);
      end else begin
        burst_len--;
      end
      r_valid <= (rd_q.size() > 0) && burst_on;
      if (rd_q.size() > 0) r_data <= make_beat(rd_q[0]);
    end
  end

  // ------------------------------------------------
  // Comparison process, sampled mid-cycle
  // ------------------------------------------------
  always @(negedge clk) begin
    if (sync_rst_n) begin
      check_flag("busy", busy, exp_busy);
      check_flag("done", done, exp_done);
      if (start && !exp_busy) begin
        rd_count = 0; // New run accepted at the next edge
        wr_count = 0;
      end
      if (r_valid && r_ready) void'(rd_q.pop_front());
      if (ar_valid && ar_ready) begin
        if (rd_count > `DOTP_LANES) abort_with("Read request issued after all 17 reads");
        check_addr("ar_addr", ar_addr, (rd_count == 0) ? `DOTP_ROW_BASE :
                   `DOTP_COL_BASE + dotp_pkg::addr_t'(rd_count - 1) * `DOTP_COL_STRIDE);
        rd_q.push_back(ar_addr);
        rd_count++;
      end
      if (wr_valid && wr_ready) begin
        if (wr_count != 0) abort_with("Second result write in one run");
        check_addr("wr_addr", wr_addr, exp_wr_addr);
        check_acc("wr_data", wr_data, exp_acc);
        exp_wr_addr = exp_wr_addr + `DOTP_RES_STRIDE;
        wr_count++;
      end
      exp_done = wr_valid && wr_ready;
      exp_busy = exp_busy ? !(wr_valid && wr_ready) : start;
    end
  end

  task automatic fill_run(input int run);
    for (int i = 0; i < `DOTP_LANES; i++) begin
      case (run)
        0: begin
          row_mem[i] = 32'h8000_0000;
          col_mem[i] = 32'h8000_0000;
        end
        1: begin
          row_mem[i] = i[0] ? 32'h7FFF_FFFF : 32'h8000_0000;
          col_mem[i] = 32'h7FFF_FFFF;
        end
        default: begin
          row_mem[i] = $random(seed);
          col_mem[i] = $random(seed);
          if (($random(seed) & 7) == 0) row_mem[i] = 32'h8000_0000; // Sprinkle extremes
          if (($random(seed) & 7) == 1) col_mem[i] = 32'h7FFF_FFFF;
        end
      endcase
    end
    exp_acc = dot_ref(row_mem, col_mem);
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    seed        = 32'hef99_f462;
    clk         = 1'b0;
    sync_rst_n  = 1'b0;
    start       = 1'b0;
    ar_ready    = 1'b0;
    r_valid     = 1'b0;
    r_data      = '0;
    wr_ready    = 1'b0;
    err_count   = 0;
    cycles      = 0;
    heavy       = 1'b0;
    burst_on    = 1'b0;
    burst_len   = 0;
    exp_wr_addr = `DOTP_RES_BASE;
    exp_busy    = 1'b0;
    exp_done    = 1'b0;
    rd_count    = 0;
    wr_count    = 0;
    repeat (3) @(posedge clk);
    sync_rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_flag("ar_valid", ar_valid, 1'b0); // Idle before any start
      check_flag("wr_valid", wr_valid, 1'b0);
      check_flag("r_ready", r_ready, 1'b0);
    end
    for (int run = 0; run < RUNS; run++) begin
      heavy = (run >= 4);
      fill_run(run);
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      if (heavy) begin
        repeat (3) @(posedge clk);
        start <= 1'b1; // Must be ignored while busy
        @(posedge clk);
        start <= 1'b0;
      end
      do @(negedge clk); while (!done);
      @(posedge clk);
      if (rd_count != `DOTP_LANES + 1) abort_with($sformatf("Run %0d made %0d reads", run,
                                                             rd_count));
      if (wr_count != 1) abort_with($sformatf("Run %0d made %0d writes", run, wr_count));
      @(negedge clk);
    end
    repeat (10) @(posedge clk);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/dotp_pkg.sv
src/dotp_ctrl.sv
src/dotp_counter.sv
src/row_buffer.sv
src/col_fifo.sv
src/mac_unit.sv
src/dotp_top.sv
test/tb_dotp.sv
